/* list.f */
common/soc_pkg.sv
perint/perint_decoder.sv
perint/pi1_downconverter.sv
perint/perint_resp_mux.sv
hw/reset_seq.sv
hw/devtbl.sv
hw/gpio.sv
hw/intctrl.sv
hw/soc_top.sv
bench/tb_soc.sv

/* run.sh */
#!/bin/sh
# Build and run the SoC peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module tb_soc -f list.f -o tb_soc
out=$(./obj_dir/tb_soc)
echo "$out"
if echo "$out" | grep -qF '** PASS **'; then
	exit 0
else
	exit 1
fi

/* bench/tb_soc.sv */
/*
 * Testbench for the SoC peripheral subsystem
 * Directed PI1 tests for reset, device table, GPIO,
 * interrupts and software reset
 */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int RST_CNTR_BITSZ = 4;
	localparam int GPIO_COUNT     = 8;
	localparam int CLK_PERIOD     = 40;
	localparam int NUM_TESTS      = 5;
	localparam int WAIT_LIMIT     = 100;

	// Window bases are running sums of the map sizes
	localparam xaddr_t GPIO_BASE = xaddr_t'(MAPSZ[S_DEVTBL]);
	localparam xaddr_t INTC_BASE = xaddr_t'(MAPSZ[S_DEVTBL] + MAPSZ[S_GPIO]);
	localparam xaddr_t INV_ADDR  = xaddr_t'(40);

	logic                  clk_2x_w;
	logic                  rst_p;
	pi1_op_t               pi1_op_i;
	xaddr_t                pi1_addr_i;
	xdata_t                pi1_data_i;
	xsel_t                 pi1_sel_i;
	xdata_t                pi1_data_o;
	logic                  pi1_rdy_o;
	logic [GPIO_COUNT-1:0] gp_i;
	logic [GPIO_COUNT-1:0] gp_o;
	logic                  ext_irq_i;
	logic                  ext_irq_rdy_o;
	logic                  irq_o;
	logic                  irq_ack_i;
	logic                  sys_rst_o;

	logic [15:0] lfsr_q;
	int          err_cnt;
	int          test_err_start;
	int          run_tests;
	int          fail_tests;
	string       cur_test;
	// Value the bus holds since the last read or swap
	xdata_t      exp_rdata;

	soc_top #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ),
		.GPIO_COUNT     (GPIO_COUNT)
	) DUT (
		.clk_2x_w      (clk_2x_w),
		.rst_p         (rst_p),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.gp_i          (gp_i),
		.gp_o          (gp_o),
		.ext_irq_i     (ext_irq_i),
		.ext_irq_rdy_o (ext_irq_rdy_o),
		.irq_o         (irq_o),
		.irq_ack_i     (irq_ack_i),
		.sys_rst_o     (sys_rst_o)
	);

	initial clk_2x_w = 1'b0;
	always #(CLK_PERIOD / 2) clk_2x_w = ~clk_2x_w;

	// Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return r;
	endfunction

	task automatic check_data(input string what, input xdata_t exp, input xdata_t act);
		if (act !== exp) begin
			$display("FAILED %s: %s expected %h, actual %h", cur_test, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: %s expected %b, actual %b", cur_test, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_gpio(input string what, input logic [GPIO_COUNT-1:0] exp,
			input logic [GPIO_COUNT-1:0] act);
		if (act !== exp) begin
			$display("FAILED %s: %s expected %h, actual %h", cur_test, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic wait_sys_rst(input logic level);
		int n;
		n = 0;
		@(negedge clk_2x_w);
		while (sys_rst_o !== level && n < WAIT_LIMIT) begin
			@(negedge clk_2x_w);
			n++;
		end
		if (sys_rst_o !== level) begin
			$display("%s: sys_rst_o never went to %b", cur_test, level);
			err_cnt++;
		end
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		@(negedge clk_2x_w);
		while (irq_o !== level && n < WAIT_LIMIT) begin
			@(negedge clk_2x_w);
			n++;
		end
		if (irq_o !== level) begin
			$display("%s: irq_o never went to %b", cur_test, level);
			err_cnt++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (5) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_sys_rst(1'b0);
	endtask

	// One PI1 request where the unused half carries inverted data
	task automatic bus_xfer(input pi1_op_t op, input xaddr_t addr, input data_t wdata,
			input logic upper, input sel_t strb, output xdata_t rdata);
		int n;
		n = 0;
		@(negedge clk_2x_w);
		while (!pi1_rdy_o && n < WAIT_LIMIT) begin
			@(negedge clk_2x_w);
			n++;
		end
		if (!pi1_rdy_o) begin
			$display("%s: bus never became ready", cur_test);
			err_cnt++;
		end
		@(posedge clk_2x_w);
		pi1_op_i   <= op;
		pi1_addr_i <= addr;
		pi1_data_i <= upper ? {wdata, ~wdata} : {~wdata, wdata};
		pi1_sel_i  <= upper ? {strb, 4'h0} : {4'h0, strb};
		@(posedge clk_2x_w);
		pi1_op_i <= PI1_NOP;
		@(negedge clk_2x_w);
		check_bit("pi1_rdy_o one cycle after request", 1'b0, pi1_rdy_o);
		@(negedge clk_2x_w);
		check_bit("pi1_rdy_o two cycles after request", 1'b1, pi1_rdy_o);
		rdata = pi1_data_o;
	endtask

	task automatic bus_read(input xaddr_t addr, input logic upper, input data_t exp,
			input string what);
		xdata_t rdata;
		bus_xfer(PI1_RD, addr, '0, upper, 4'hF, rdata);
		check_data(what, {exp, exp}, rdata);
		exp_rdata = {exp, exp};
	endtask

	task automatic bus_write(input xaddr_t addr, input logic upper, input data_t wdata,
			input sel_t strb);
		xdata_t rdata;
		bus_xfer(PI1_WR, addr, wdata, upper, strb, rdata);
		check_data("read data held over a write", exp_rdata, rdata);
	endtask

	task automatic bus_swap(input xaddr_t addr, input logic upper, input data_t wdata,
			input data_t exp_old, input string what);
		xdata_t rdata;
		bus_xfer(PI1_RW, addr, wdata, upper, 4'hF, rdata);
		check_data(what, {exp_old, exp_old}, rdata);
		exp_rdata = {exp_old, exp_old};
	endtask

	// Acknowledge and stop at the cycle where the source ready pulses
	task automatic pulse_ack();
		@(posedge clk_2x_w);
		irq_ack_i <= 1'b1;
		@(posedge clk_2x_w);
		irq_ack_i <= 1'b0;
		@(negedge clk_2x_w);
	endtask

	task automatic start_test(input string name);
		cur_test       = name;
		test_err_start = err_cnt;
	endtask

	task automatic end_test();
		run_tests++;
		if (err_cnt == test_err_start) begin
			$display("test %s passed", cur_test);
		end else begin
			fail_tests++;
			$display("test %s failed with %0d errors", cur_test, err_cnt - test_err_start);
		end
	endtask

	task automatic test_reset();
		start_test("reset");
		check_bit("pi1_rdy_o", 1'b1, pi1_rdy_o);
		check_bit("irq_o", 1'b0, irq_o);
		check_bit("ext_irq_rdy_o", 1'b0, ext_irq_rdy_o);
		check_gpio("gp_o", '0, gp_o);
		// A nonzero read first so the invalid device has to clear the data
		bus_read(xaddr_t'(0), 1'b1, data_t'(SLAVE_COUNT), "slave count before invalid read");
		bus_read(INV_ADDR, 1'b0, '0, "invalid address read");
		end_test();
	endtask

	task automatic test_devtbl();
		start_test("device table");
		bus_read(xaddr_t'(0), 1'b1, data_t'(SLAVE_COUNT), "slave count");
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			bus_read(xaddr_t'(1 + i), 1'b0, data_t'(DEV_ID[i]), "device id");
			bus_read(xaddr_t'(1 + i), 1'b1, data_t'(MAPSZ[i] * 8), "map size in bytes");
		end
		end_test();
	endtask

	task automatic test_gpio_out();
		data_t v;
		sel_t  strb;
		data_t model;
		start_test("gpio output");
		model = '0;
		for (int k = 0; k < 6; k++) begin
			v    = rand_bits(32);
			strb = sel_t'(rand_bits(4));
			bus_write(GPIO_BASE, 1'b1, v, strb);
			// Only strobed bytes reach the output register
			for (int b = 0; b < GPIO_COUNT; b++) begin
				if (strb[b / 8]) begin
					model[b] = v[b];
				end
			end
			check_gpio("gp_o after write", model[GPIO_COUNT-1:0], gp_o);
			bus_read(GPIO_BASE, 1'b1, model, "output readback");
		end
		v = data_t'(rand_bits(GPIO_COUNT));
		bus_swap(GPIO_BASE, 1'b1, v, model, "swap old value");
		check_gpio("gp_o after swap", v[GPIO_COUNT-1:0], gp_o);
		bus_read(GPIO_BASE, 1'b1, v, "readback after swap");
		end_test();
	endtask

	task automatic test_gpio_irq();
		start_test("gpio interrupt");
		bus_write(xaddr_t'(GPIO_BASE + 1), 1'b0, 32'h1, 4'h1);
		bus_read(xaddr_t'(GPIO_BASE + 1), 1'b0, 32'h1, "interrupt mask");
		@(posedge clk_2x_w);
		gp_i <= gp_i ^ GPIO_COUNT'(1);
		wait_irq(1'b1);
		bus_read(INTC_BASE, 1'b0, data_t'(INT_SRC_GPIO), "served source");
		pulse_ack();
		check_bit("irq_o after acknowledge", 1'b0, irq_o);
		check_bit("ext_irq_rdy_o for gpio acknowledge", 1'b0, ext_irq_rdy_o);
		repeat (4) @(negedge clk_2x_w);
		check_bit("irq_o once request cleared", 1'b0, irq_o);

		// Two sync stages and the change flop before the external line joins
		@(posedge clk_2x_w);
		gp_i <= gp_i ^ GPIO_COUNT'(1);
		repeat (3) @(posedge clk_2x_w);
		ext_irq_i <= 1'b1;
		wait_irq(1'b1);
		bus_read(INTC_BASE, 1'b0, data_t'(INT_SRC_GPIO), "first of two sources");
		bus_read(INTC_BASE, 1'b1, 32'h3, "pending vector");
		pulse_ack();
		check_bit("irq_o after first acknowledge", 1'b0, irq_o);
		wait_irq(1'b1);
		bus_read(INTC_BASE, 1'b0, data_t'(INT_SRC_EXT), "second of two sources");
		pulse_ack();
		check_bit("irq_o after second acknowledge", 1'b0, irq_o);
		check_bit("ext_irq_rdy_o pulse", 1'b1, ext_irq_rdy_o);
		@(posedge clk_2x_w);
		ext_irq_i <= 1'b0;
		@(negedge clk_2x_w);
		check_bit("ext_irq_rdy_o pulse length", 1'b0, ext_irq_rdy_o);
		repeat (4) @(negedge clk_2x_w);
		check_bit("irq_o with nothing pending", 1'b0, irq_o);
		end_test();
	endtask

	task automatic test_sw_reset();
		start_test("software reset");
		bus_write(GPIO_BASE, 1'b1, 32'hA5, 4'hF);
		check_gpio("gp_o before warm reset", 8'hA5, gp_o);
		bus_write(xaddr_t'(0), 1'b0, 32'h2, 4'h1);
		wait_sys_rst(1'b1);
		wait_sys_rst(1'b0);
		check_gpio("gp_o after warm reset", '0, gp_o);
		bus_read(xaddr_t'(0), 1'b0, '0, "reset bits after warm reset");

		// Power-off holds until the board reset
		bus_write(xaddr_t'(0), 1'b0, 32'h1, 4'h1);
		wait_sys_rst(1'b1);
		repeat (2 ** RST_CNTR_BITSZ) begin
			@(negedge clk_2x_w);
			check_bit("sys_rst_o during power-off", 1'b1, sys_rst_o);
		end
		apply_reset();
		check_bit("pi1_rdy_o after board reset", 1'b1, pi1_rdy_o);
		bus_read(xaddr_t'(0), 1'b0, '0, "reset bits after board reset");
		end_test();
	endtask

	initial begin
		#(NUM_TESTS * 400 * CLK_PERIOD);
		$display("Timeout, the tests did not finish in the expected time");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		lfsr_q     = 16'd57;
		err_cnt    = 0;
		run_tests  = 0;
		fail_tests = 0;
		cur_test   = "init";
		exp_rdata  = '0;
		rst_p      = 1'b1;
		pi1_op_i   = PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		gp_i       = '0;
		ext_irq_i  = 1'b0;
		irq_ack_i  = 1'b0;
		apply_reset();

		test_reset();
		test_devtbl();
		test_gpio_out();
		test_gpio_irq();
		test_sw_reset();

		$display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
			run_tests, run_tests - fail_tests, fail_tests, err_cnt);
		if (fail_tests == 0 && err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* hw/soc_top.sv */
/*
 * SoC peripheral subsystem top level
 * Reset sequencer, PI1 router with per-slave downconverters,
 * device table, GPIO and interrupt controller
 */
`timescale 1ns/1ps

module soc_top #(
	parameter int RST_CNTR_BITSZ = 4,
	parameter int GPIO_COUNT     = 8
) (
	input  logic                    clk_2x_w,
	input  logic                    rst_p,
	input  soc_pkg::pi1_op_t        pi1_op_i,
	input  soc_pkg::xaddr_t         pi1_addr_i,
	input  soc_pkg::xdata_t         pi1_data_i,
	input  soc_pkg::xsel_t          pi1_sel_i,
	output soc_pkg::xdata_t         pi1_data_o,
	output logic                    pi1_rdy_o,
	input  logic [GPIO_COUNT-1:0]   gp_i,
	output logic [GPIO_COUNT-1:0]   gp_o,
	input  logic                    ext_irq_i,
	output logic                    ext_irq_rdy_o,
	output logic                    irq_o,
	input  logic                    irq_ack_i,
	output logic                    sys_rst_o
);
	import soc_pkg::*;

	logic rst0_w;
	logic rst1_w;
	logic gpio_intrqst_w;
	logic gpio_intrdy_w;

	// Router side, one entry per slave window
	slave_idx_t slave_idx_w;
	pi1_op_t    s_op_w     [SLAVE_COUNT];
	xaddr_t     s_offset_w [SLAVE_COUNT];
	xdata_t     s_wdata_w  [SLAVE_COUNT];
	xsel_t      s_sel_w    [SLAVE_COUNT];
	xdata_t     s_rdata_w  [SLAVE_COUNT];
	logic       s_rdy_w    [SLAVE_COUNT];

	// Peripheral side after narrowing
	pi1_op_t    p_op_w    [SLAVE_COUNT];
	paddr_t     p_addr_w  [SLAVE_COUNT];
	data_t      p_wdata_w [SLAVE_COUNT];
	sel_t       p_sel_w   [SLAVE_COUNT];
	data_t      p_rdata_w [SLAVE_COUNT];
	logic       p_rdy_w   [SLAVE_COUNT];

	reset_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_reset_seq (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.rst0_i    (rst0_w),
		.rst1_i    (rst1_w),
		.sys_rst_o (sys_rst_o)
	);

	perint_decoder u_decoder (
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.s_op_o      (s_op_w),
		.s_offset_o  (s_offset_w),
		.s_data_o    (s_wdata_w),
		.s_sel_o     (s_sel_w),
		.slave_idx_o (slave_idx_w)
	);

	for (genvar i = 0; i < SLAVE_COUNT; i++) begin : g_dnconv
		pi1_downconverter u_dnconv (
			.m_op_i     (s_op_w[i]),
			.m_offset_i (s_offset_w[i]),
			.m_data_i   (s_wdata_w[i]),
			.m_sel_i    (s_sel_w[i]),
			.m_data_o   (s_rdata_w[i]),
			.m_rdy_o    (s_rdy_w[i]),
			.p_op_o     (p_op_w[i]),
			.p_addr_o   (p_addr_w[i]),
			.p_data_o   (p_wdata_w[i]),
			.p_sel_o    (p_sel_w[i]),
			.p_data_i   (p_rdata_w[i]),
			.p_rdy_i    (p_rdy_w[i])
		);
	end

	perint_resp_mux u_resp_mux (
		.clk_2x_w    (clk_2x_w),
		.sys_rst_i   (sys_rst_o),
		.op_i        (pi1_op_i),
		.slave_idx_i (slave_idx_w),
		.s_data_i    (s_rdata_w),
		.s_rdy_i     (s_rdy_w),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o)
	);

	devtbl u_devtbl (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.op_i      (p_op_w[S_DEVTBL]),
		.addr_i    (p_addr_w[S_DEVTBL]),
		.data_i    (p_wdata_w[S_DEVTBL]),
		.sel_i     (p_sel_w[S_DEVTBL]),
		.data_o    (p_rdata_w[S_DEVTBL]),
		.rdy_o     (p_rdy_w[S_DEVTBL]),
		.rst0_o    (rst0_w),
		.rst1_o    (rst1_w)
	);

	gpio #(
		.GPIO_COUNT (GPIO_COUNT)
	) u_gpio (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.op_i      (p_op_w[S_GPIO]),
		.addr_i    (p_addr_w[S_GPIO]),
		.data_i    (p_wdata_w[S_GPIO]),
		.sel_i     (p_sel_w[S_GPIO]),
		.data_o    (p_rdata_w[S_GPIO]),
		.rdy_o     (p_rdy_w[S_GPIO]),
		.gp_i      (gp_i),
		.gp_o      (gp_o),
		.intrqst_o (gpio_intrqst_w),
		.intrdy_i  (gpio_intrdy_w)
	);

	intctrl u_intctrl (
		.clk_2x_w       (clk_2x_w),
		.sys_rst_i      (sys_rst_o),
		.op_i           (p_op_w[S_INTCTRL]),
		.addr_i         (p_addr_w[S_INTCTRL]),
		.data_i         (p_wdata_w[S_INTCTRL]),
		.sel_i          (p_sel_w[S_INTCTRL]),
		.data_o         (p_rdata_w[S_INTCTRL]),
		.rdy_o          (p_rdy_w[S_INTCTRL]),
		.gpio_intrqst_i (gpio_intrqst_w),
		.gpio_intrdy_o  (gpio_intrdy_w),
		.ext_irq_i      (ext_irq_i),
		.ext_irq_rdy_o  (ext_irq_rdy_o),
		.irq_ack_i      (irq_ack_i),
		.irq_o          (irq_o)
	);

endmodule

/* hw/intctrl.sv */
/*
 * Interrupt controller
 * Picks the lowest pending source, raises irq_o to the single
 * destination and returns the acknowledge to that source
 */
`timescale 1ns/1ps

module intctrl (
	input  logic             clk_2x_w,
	input  logic             sys_rst_i,
	input  soc_pkg::pi1_op_t op_i,
	input  soc_pkg::paddr_t  addr_i,
	input  soc_pkg::data_t   data_i,
	input  soc_pkg::sel_t    sel_i,
	output soc_pkg::data_t   data_o,
	output logic             rdy_o,
	input  logic             gpio_intrqst_i,
	output logic             gpio_intrdy_o,
	input  logic             ext_irq_i,
	output logic             ext_irq_rdy_o,
	input  logic             irq_ack_i,
	output logic             irq_o
);
	import soc_pkg::*;

	localparam int SRC_W = $clog2(INT_SRC_COUNT);

	int_state_t               state_q;
	logic [SRC_W-1:0]         src_q;
	logic [SRC_W-1:0]         low_src;
	logic [INT_SRC_COUNT-1:0] pending;
	logic [INT_SRC_COUNT-1:0] ack_q;
	logic                     busy_q;
	logic                     accept;

	assign pending = {ext_irq_i, gpio_intrqst_i};
	assign accept  = (op_i != PI1_NOP) && rdy_o;
	assign rdy_o   = !busy_q;
	assign irq_o   = (state_q == INT_WAIT_ACK);

	assign gpio_intrdy_o = ack_q[INT_SRC_GPIO];
	assign ext_irq_rdy_o = ack_q[INT_SRC_EXT];

	// Source being acknowledged still shows its request this cycle
	always_comb begin
		low_src = '0;
		for (int i = INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (pending[i] && !ack_q[i]) begin
				low_src = SRC_W'(i);
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			state_q <= INT_IDLE;
			src_q   <= '0;
			ack_q   <= '0;
			busy_q  <= 1'b0;
		end else begin
			busy_q <= accept;
			ack_q  <= '0;
			case (state_q)
				INT_IDLE: begin
					if (|(pending & ~ack_q)) begin
						src_q   <= low_src;
						state_q <= INT_WAIT_ACK;
					end
				end
				INT_WAIT_ACK: begin
					if (irq_ack_i) begin
						ack_q[src_q] <= 1'b1;
						state_q      <= INT_IDLE;
					end
				end
				default: state_q <= INT_IDLE;
			endcase
		end
	end

	// Read only, write data and strobes have nothing to land in
	always_ff @(posedge clk_2x_w) begin
		if (accept && op_i != PI1_WR) begin
			case (addr_i)
				paddr_t'(0): data_o <= data_t'(src_q);
				paddr_t'(1): data_o <= data_t'(pending);
				default:     data_o <= '0;
			endcase
		end
	end

endmodule

/* hw/gpio.sv */
/*
 * GPIO block
 * Synchronized inputs, byte-writable outputs and an interrupt
 * on any change of a masked input
 */
`timescale 1ns/1ps

module gpio #(
	parameter int GPIO_COUNT = 8
) (
	input  logic                  clk_2x_w,
	input  logic                  sys_rst_i,
	input  soc_pkg::pi1_op_t      op_i,
	input  soc_pkg::paddr_t       addr_i,
	input  soc_pkg::data_t        data_i,
	input  soc_pkg::sel_t         sel_i,
	output soc_pkg::data_t        data_o,
	output logic                  rdy_o,
	input  logic [GPIO_COUNT-1:0] gp_i,
	output logic [GPIO_COUNT-1:0] gp_o,
	output logic                  intrqst_o,
	input  logic                  intrdy_i
);
	import soc_pkg::*;

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic [GPIO_COUNT-1:0] prev_q;
	logic [GPIO_COUNT-1:0] mask_q;
	logic                  busy_q;
	logic                  accept;
	logic                  wr;
	data_t                 rd_data;

	assign accept = (op_i != PI1_NOP) && rdy_o;
	assign wr     = accept && op_i != PI1_RD;
	assign rdy_o  = !busy_q;

	// Two flops against metastability, one more to spot edges
	always_ff @(posedge clk_2x_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_comb begin
		case (addr_i)
			paddr_t'(0): rd_data = data_t'(sync2_q);
			paddr_t'(1): rd_data = data_t'(gp_o);
			paddr_t'(2): rd_data = data_t'(mask_q);
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			busy_q    <= 1'b0;
			gp_o      <= '0;
			mask_q    <= '0;
			intrqst_o <= 1'b0;
		end else begin
			busy_q <= accept;
			for (int b = 0; b < GPIO_COUNT; b++) begin
				if (wr && sel_i[b/8] && addr_i == paddr_t'(1)) begin
					gp_o[b] <= data_i[b];
				end
				if (wr && sel_i[b/8] && addr_i == paddr_t'(2)) begin
					mask_q[b] <= data_i[b];
				end
			end
			// A fresh change wins over the acknowledge
			if (|((sync2_q ^ prev_q) & mask_q)) begin
				intrqst_o <= 1'b1;
			end else if (intrdy_i) begin
				intrqst_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (accept && op_i != PI1_WR) begin
			data_o <= rd_data;
		end
	end

endmodule

/* hw/devtbl.sv */
/*
 * Device table
 * Reports slave count, device ids and window sizes,
 * and holds the software reset bits
 */
`timescale 1ns/1ps

module devtbl (
	input  logic             clk_2x_w,
	input  logic             sys_rst_i,
	input  soc_pkg::pi1_op_t op_i,
	input  soc_pkg::paddr_t  addr_i,
	input  soc_pkg::data_t   data_i,
	input  soc_pkg::sel_t    sel_i,
	output soc_pkg::data_t   data_o,
	output logic             rdy_o,
	output logic             rst0_o,
	output logic             rst1_o
);
	import soc_pkg::*;

	logic  busy_q;
	logic  accept;
	data_t rd_data;

	assign accept = (op_i != PI1_NOP) && rdy_o;
	assign rdy_o  = !busy_q;

	always_comb begin
		rd_data = '0;
		if (addr_i == paddr_t'(0)) begin
			rd_data = {{(ARCH_W-2){1'b0}}, rst1_o, rst0_o};
		end else if (addr_i == paddr_t'(1)) begin
			rd_data = data_t'(SLAVE_COUNT);
		end
		// Two words per slave, id then size in bytes
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			if (addr_i == paddr_t'(2 + 2 * i)) begin
				rd_data = data_t'(DEV_ID[i]);
			end
			if (addr_i == paddr_t'(3 + 2 * i)) begin
				rd_data = data_t'(MAPSZ[i] * 8);
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			busy_q <= 1'b0;
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else begin
			busy_q <= accept;
			if (accept && op_i != PI1_RD && addr_i == paddr_t'(0) && sel_i[0]) begin
				rst0_o <= data_i[0];
				rst1_o <= data_i[1];
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (accept && op_i != PI1_WR) begin
			data_o <= rd_data;
		end
	end

endmodule

/* hw/reset_seq.sv */
/*
 * Reset sequencer
 * Stretches the board reset, reloads on software warm reset and
 * latches software power-off until the next board reset
 */
`timescale 1ns/1ps

module reset_seq #(
	parameter int RST_CNTR_BITSZ = 4
) (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);
	logic [RST_CNTR_BITSZ-1:0] cntr_q;
	logic                      pwroff_q;
	logic                      sw_warm;
	logic                      sw_pwroff;

	// rst1 set means warm reset, with or without rst0
	assign sw_warm   = rst1_i;
	assign sw_pwroff = rst0_i && !rst1_i;

	always_ff @(posedge clk_2x_w) begin
		if (rst_p || sw_warm) begin
			cntr_q <= '1;
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// Only the board reset brings the system back from power-off
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (cntr_q != '0) || pwroff_q;

endmodule

/* perint/perint_resp_mux.sv */
/*
 * PerInt response multiplexer
 * Remembers which slave took the last request and returns its
 * ready and data, stands in for the invalid device itself
 */
`timescale 1ns/1ps

module perint_resp_mux (
	input  logic                clk_2x_w,
	input  logic                sys_rst_i,
	input  soc_pkg::pi1_op_t    op_i,
	input  soc_pkg::slave_idx_t slave_idx_i,
	input  soc_pkg::xdata_t     s_data_i [soc_pkg::SLAVE_COUNT],
	input  logic                s_rdy_i  [soc_pkg::SLAVE_COUNT],
	output soc_pkg::xdata_t     pi1_data_o,
	output logic                pi1_rdy_o
);
	import soc_pkg::*;

	slave_idx_t rdy_idx_q;
	slave_idx_t data_idx_q;
	logic       inv_busy_q;
	logic       accept;

	assign accept = (op_i != PI1_NOP) && pi1_rdy_o;

	// Invalid device falls through as default, data zero
	always_comb begin
		pi1_rdy_o  = !inv_busy_q;
		pi1_data_o = '0;
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			if (rdy_idx_q == slave_idx_t'(i)) begin
				pi1_rdy_o = s_rdy_i[i];
			end
			if (data_idx_q == slave_idx_t'(i)) begin
				pi1_data_o = s_data_i[i];
			end
		end
	end

	// Writes leave the data source alone so the last read value stays
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rdy_idx_q  <= slave_idx_t'(S_INVALID);
			data_idx_q <= slave_idx_t'(S_INVALID);
			inv_busy_q <= 1'b0;
		end else begin
			inv_busy_q <= accept && (slave_idx_i == slave_idx_t'(S_INVALID));
			if (accept) begin
				rdy_idx_q <= slave_idx_i;
			end
			if (accept && op_i != PI1_WR) begin
				data_idx_q <= slave_idx_i;
			end
		end
	end

endmodule

/* perint/pi1_downconverter.sv */
/*
 * PI1 downconverter
 * Narrows a 64-bit slave request to one 32-bit peripheral word
 * and spreads the peripheral response over both halves
 */
`timescale 1ns/1ps

module pi1_downconverter (
	input  soc_pkg::pi1_op_t m_op_i,
	input  soc_pkg::xaddr_t  m_offset_i,
	input  soc_pkg::xdata_t  m_data_i,
	input  soc_pkg::xsel_t   m_sel_i,
	output soc_pkg::xdata_t  m_data_o,
	output logic             m_rdy_o,
	output soc_pkg::pi1_op_t p_op_o,
	output soc_pkg::paddr_t  p_addr_o,
	output soc_pkg::data_t   p_data_o,
	output soc_pkg::sel_t    p_sel_o,
	input  soc_pkg::data_t   p_data_i,
	input  logic             p_rdy_i
);
	import soc_pkg::*;

	logic upper;

	// Any strobe in the upper four bytes targets the odd word
	assign upper = |m_sel_i[XARCH_W/8-1:ARCH_W/8];

	assign p_op_o   = m_op_i;
	assign p_addr_o = {m_offset_i[PER_ADDR_W-2:0], upper};

	always_comb begin
		if (upper) begin
			p_data_o = m_data_i[XARCH_W-1:ARCH_W];
			p_sel_o  = m_sel_i[XARCH_W/8-1:ARCH_W/8];
		end else begin
			p_data_o = m_data_i[ARCH_W-1:0];
			p_sel_o  = m_sel_i[ARCH_W/8-1:0];
		end
	end

	// Master picks whichever half it asked for
	assign m_data_o = {p_data_i, p_data_i};
	assign m_rdy_o  = p_rdy_i;

endmodule

/* perint/perint_decoder.sv */
/*
 * PerInt address decoder
 * Maps a router address onto a slave window and its offset,
 * and sends the operation to the hit slave only
 */
`timescale 1ns/1ps

module perint_decoder (
	input  soc_pkg::pi1_op_t    pi1_op_i,
	input  soc_pkg::xaddr_t     pi1_addr_i,
	input  soc_pkg::xdata_t     pi1_data_i,
	input  soc_pkg::xsel_t      pi1_sel_i,
	output soc_pkg::pi1_op_t    s_op_o     [soc_pkg::SLAVE_COUNT],
	output soc_pkg::xaddr_t     s_offset_o [soc_pkg::SLAVE_COUNT],
	output soc_pkg::xdata_t     s_data_o   [soc_pkg::SLAVE_COUNT],
	output soc_pkg::xsel_t      s_sel_o    [soc_pkg::SLAVE_COUNT],
	output soc_pkg::slave_idx_t slave_idx_o
);
	import soc_pkg::*;

	xaddr_t hit_base;

	// Windows sit back to back from address 0
	always_comb begin
		xaddr_t base;
		xaddr_t limit;
		base        = '0;
		hit_base    = '0;
		slave_idx_o = slave_idx_t'(S_INVALID);
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			limit = base + xaddr_t'(MAPSZ[i]);
			if (pi1_addr_i >= base && pi1_addr_i < limit) begin
				slave_idx_o = slave_idx_t'(i);
				hit_base    = base;
			end
			base = limit;
		end
	end

	always_comb begin
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			s_op_o[i]     = (slave_idx_o == slave_idx_t'(i)) ? pi1_op_i : PI1_NOP;
			s_offset_o[i] = pi1_addr_i - hit_base;
			s_data_o[i]   = pi1_data_i;
			s_sel_o[i]    = pi1_sel_i;
		end
	end

endmodule

/* common/soc_pkg.sv */
/*
 * SoC shared definitions
 * PI1 bus opcodes and widths, slave map, device ids and interrupt sources
 */
package soc_pkg;

	// PI1 operations, RW swaps old and new value
	typedef enum logic [1:0] {
		PI1_NOP = 2'd0,
		PI1_WR  = 2'd1,
		PI1_RD  = 2'd2,
		PI1_RW  = 2'd3
	} pi1_op_t;

	// Router side is 64 bits wide, peripherals are 32 bits wide
	localparam int XARCH_W    = 64;
	localparam int ARCH_W     = 32;
	localparam int ADDR_W     = 16;
	localparam int PER_ADDR_W = 8;

	typedef logic [XARCH_W-1:0]     xdata_t;
	typedef logic [XARCH_W/8-1:0]   xsel_t;
	typedef logic [ARCH_W-1:0]      data_t;
	typedef logic [ARCH_W/8-1:0]    sel_t;
	typedef logic [ADDR_W-1:0]      xaddr_t;
	typedef logic [PER_ADDR_W-1:0]  paddr_t;

	// Slave windows in address order
	localparam int S_DEVTBL    = 0;
	localparam int S_GPIO      = 1;
	localparam int S_INTCTRL   = 2;
	localparam int SLAVE_COUNT = 3;
	localparam int S_INVALID   = SLAVE_COUNT;

	typedef logic [1:0] slave_idx_t;

	// Window sizes in 64-bit words, bases follow as running sums
	localparam int unsigned MAPSZ [SLAVE_COUNT] = '{16, 8, 8};

	// Ids reported through the device table
	localparam int unsigned DEV_ID [SLAVE_COUNT] = '{7, 6, 3};

	// Interrupt sources, lower index wins
	localparam int INT_SRC_GPIO  = 0;
	localparam int INT_SRC_EXT   = 1;
	localparam int INT_SRC_COUNT = 2;

	typedef enum logic {
		INT_IDLE,
		INT_WAIT_ACK
	} int_state_t;

endpackage
